/* muldiv_pkg.sv */
//==========================================================================
// Shared types and operation encoding for the RV32 M-extension execute unit.
// Compile it ahead of the modules that import it.
//==========================================================================

package muldiv_pkg;

    // the multiplier works on halves of this width
    localparam int half_w = 16;

    // operand or result word
    typedef logic [2*half_w-1:0] word_t;

    // bit 0 marks operand A as signed and bit 1 marks operand B as signed
    typedef logic [1:0] signed_mode_t;

    // accumulator of the 17x17 multiply-accumulate
    // two sign-extended halves need 34 bits and the extra bit keeps the sum from wrapping
    typedef logic [2*half_w+2:0] mac_t;

    // the values follow funct3 of the M instructions
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } muldiv_op_e;

endpackage

/* mul.sv */
//==========================================================================
// Multi-cycle 32x32 multiplier built around one 17x17 multiply-accumulate.
// Partial products run low-low, low-high, high-low, high-high and the
// sequence stops early for short operands or for a low-word result.
//==========================================================================

`timescale 1ns/1ps

module mul (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     stall_i,
    input  muldiv_pkg::word_t        first_operand_i,
    input  muldiv_pkg::word_t        second_operand_i,
    input  muldiv_pkg::signed_mode_t signed_mode_i,
    input  logic                     enable_i,
    input  logic                     mul_low_i,
    input  logic                     single_cycle_i,
    output logic                     hold_o,
    output muldiv_pkg::word_t        result_o
);

    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        st_al_bl,
        st_al_bh,
        st_ah_bl,
        st_ah_bh
    } mul_state_e;

    mul_state_e      state_q;
    mul_state_e      state_d;
    logic            last_cycle;
    logic            freeze;
    logic            signed_mult;
    logic [half_w:0] op_al;
    logic [half_w:0] op_ah;
    logic [half_w:0] op_bl;
    logic [half_w:0] op_bh;
    logic [half_w:0] op_a;
    logic [half_w:0] op_b;
    mac_t            accum;
    mac_t            mac_sum;
    mac_t            mac_next;
    mac_t            mac_q;

    always_comb begin
        case (state_q)
            st_al_bl: state_d = enable_i ? st_al_bh : st_al_bl;
            st_al_bh: state_d = single_cycle_i ? st_al_bl : st_ah_bl;
            st_ah_bl: state_d = mul_low_i ? st_al_bl : st_ah_bh;
            st_ah_bh: state_d = st_al_bl;
            default:  state_d = st_al_bl;
        endcase
    end

    assign last_cycle = (state_q == st_ah_bh)
                     || (state_q == st_ah_bl && mul_low_i)
                     || (state_q == st_al_bh && single_cycle_i);

    assign hold_o = enable_i && !last_cycle;

    // the pipeline may hold the result only while it is on the output
    assign freeze = stall_i && last_cycle;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= st_al_bl;
        end else if (!freeze) begin
            state_q <= state_d;
        end
    end

    // low halves carry a sign bit only when the whole operand fits in one half
    assign op_al = {single_cycle_i && signed_mode_i[0] && first_operand_i[half_w-1],
                    first_operand_i[half_w-1:0]};
    assign op_ah = {signed_mode_i[0] && first_operand_i[2*half_w-1],
                    first_operand_i[2*half_w-1:half_w]};
    assign op_bl = {single_cycle_i && signed_mode_i[1] && second_operand_i[half_w-1],
                    second_operand_i[half_w-1:0]};
    assign op_bh = {signed_mode_i[1] && second_operand_i[2*half_w-1],
                    second_operand_i[2*half_w-1:half_w]};

    assign op_a = (state_q inside {st_al_bl, st_al_bh}) ? op_al : op_ah;
    assign op_b = (state_q inside {st_al_bl, st_ah_bl}) ? op_bl : op_bh;

    assign signed_mult = (signed_mode_i != 2'b00);

    always_comb begin
        case (state_q)
            st_al_bl: accum = '0;
            st_al_bh: accum = mac_t'(mac_q[2*half_w-1:half_w]);
            st_ah_bl: accum = mul_low_i ? mac_t'(mac_q[2*half_w-1:half_w]) : mac_q;
            // middle sum shifted down one half with its sign carried along
            st_ah_bh: accum = {{(half_w+1){signed_mult && mac_q[2*half_w+1]}},
                               mac_q[2*half_w+1:half_w]};
            default:  accum = '0;
        endcase
    end

    assign mac_sum = $signed(op_a) * $signed(op_b) + $signed(accum);

    always_comb begin
        mac_next = mac_sum;
        if (state_q == st_al_bh && single_cycle_i) begin
            // short operands are complete after the low-low product
            mac_next = mac_q;
        end else if (mul_low_i && (state_q inside {st_al_bh, st_ah_bl})) begin
            // for a low word only the lower half of each cross term matters
            mac_next = mac_t'({mac_sum[half_w-1:0], mac_q[half_w-1:0]});
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mac_q <= mac_next;
        end
    end

    assign result_o = mac_next[2*half_w-1:0];

endmodule

/* div.sv */
//==========================================================================
// Serial restoring divider for DIV, DIVU, REM and REMU.
// One load cycle, 32 shift-subtract steps and one result cycle.
// Divide by zero and signed overflow finish in the first cycle.
//==========================================================================

`timescale 1ns/1ps

module div (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              stall_i,
    input  muldiv_pkg::word_t dividend_i,
    input  muldiv_pkg::word_t divisor_i,
    input  logic              enable_i,
    input  logic              signed_i,
    input  logic              rem_i,
    output logic              hold_o,
    output muldiv_pkg::word_t result_o
);

    import muldiv_pkg::*;

    localparam int word_w = $bits(word_t);
    localparam int step_w = $clog2(word_w);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

    div_state_e          state_q;
    logic [step_w-1:0]   step_q;
    logic                div_zero;
    logic                overflow;
    logic                special;
    logic                neg_a;
    logic                neg_b;
    word_t               abs_a;
    word_t               abs_b;
    word_t               special_result;
    word_t               final_result;
    word_t               rem_q;
    word_t               quo_q;
    word_t               divisor_q;
    logic                neg_quo_q;
    logic                neg_rem_q;
    logic [word_w:0]     rem_shift;
    logic [word_w+1:0]   trial;

    assign div_zero = (divisor_i == '0);
    assign overflow = signed_i
                   && (dividend_i == {1'b1, {(word_w-1){1'b0}}})
                   && (divisor_i == '1);
    assign special  = div_zero || overflow;

    always_comb begin
        if (div_zero) begin
            special_result = rem_i ? dividend_i : '1;
        end else begin
            special_result = rem_i ? '0 : dividend_i;
        end
    end

    assign neg_a = signed_i && dividend_i[word_w-1];
    assign neg_b = signed_i && divisor_i[word_w-1];
    assign abs_a = neg_a ? -dividend_i : dividend_i;
    assign abs_b = neg_b ? -divisor_i : divisor_i;

    // next dividend bit shifts into the partial remainder each step
    assign rem_shift = {rem_q, quo_q[word_w-1]};
    assign trial     = {1'b0, rem_shift} - {2'b00, divisor_q};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= st_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    step_q <= '0;
                    if (enable_i && !special) begin
                        state_q <= st_run;
                    end
                end
                st_run: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == step_w'(word_w - 1)) begin
                        state_q <= st_done;
                    end
                end
                st_done: begin
                    if (!stall_i) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle) begin
            rem_q     <= '0;
            quo_q     <= abs_a;
            divisor_q <= abs_b;
            neg_quo_q <= neg_a ^ neg_b;
            neg_rem_q <= neg_a;
        end else if (state_q == st_run) begin
            quo_q <= {quo_q[word_w-2:0], !trial[word_w+1]};
            if (!trial[word_w+1]) begin
                rem_q <= trial[word_w-1:0];
            end else begin
                rem_q <= rem_shift[word_w-1:0];
            end
        end
    end

    // the remainder takes the sign of the dividend
    always_comb begin
        if (rem_i) begin
            final_result = neg_rem_q ? -rem_q : rem_q;
        end else begin
            final_result = neg_quo_q ? -quo_q : quo_q;
        end
    end

    assign result_o = (state_q == st_idle) ? special_result : final_result;

    assign hold_o = enable_i && !((state_q == st_idle && special) || state_q == st_done);

endmodule

/* muldiv_ctrl.sv */
//==========================================================================
// Operation decode for the multiply/divide unit.
// Steers the unit enables and modes, spots short MUL operands and picks
// busy and result from the active unit.
//==========================================================================

`timescale 1ns/1ps

module muldiv_ctrl (
    input  logic                     op_valid_i,
    input  muldiv_pkg::muldiv_op_e   op_i,
    input  muldiv_pkg::word_t        operand_a_i,
    input  muldiv_pkg::word_t        operand_b_i,
    input  logic                     mul_hold_i,
    input  muldiv_pkg::word_t        mul_result_i,
    input  logic                     div_hold_i,
    input  muldiv_pkg::word_t        div_result_i,
    output logic                     mul_enable_o,
    output muldiv_pkg::signed_mode_t signed_mode_o,
    output logic                     mul_low_o,
    output logic                     single_cycle_o,
    output logic                     div_enable_o,
    output logic                     div_signed_o,
    output logic                     div_rem_o,
    output logic                     busy_o,
    output muldiv_pkg::word_t        result_o
);

    import muldiv_pkg::*;

    logic is_div;
    logic a_zext;
    logic a_sext;
    logic b_zext;
    logic b_sext;

    assign is_div = op_i inside {op_div, op_divu, op_rem, op_remu};

    // an upper half that only repeats bit 15 makes the operand fit a 17-bit half
    assign a_zext = (operand_a_i[2*half_w-1:half_w] == '0);
    assign a_sext = (operand_a_i[2*half_w-1:half_w] == '1) && operand_a_i[half_w-1];
    assign b_zext = (operand_b_i[2*half_w-1:half_w] == '0);
    assign b_sext = (operand_b_i[2*half_w-1:half_w] == '1) && operand_b_i[half_w-1];

    assign mul_enable_o   = op_valid_i && !is_div;
    assign div_enable_o   = op_valid_i && is_div;
    assign mul_low_o      = (op_i == op_mul);
    assign single_cycle_o = mul_low_o && (a_zext || a_sext) && (b_zext || b_sext);
    assign div_signed_o   = op_i inside {op_div, op_rem};
    assign div_rem_o      = op_i inside {op_rem, op_remu};

    always_comb begin
        case (op_i)
            // the low word ignores signedness so each operand's mode follows its extension
            op_mul:    signed_mode_o = {b_sext, a_sext};
            op_mulh:   signed_mode_o = 2'b11;
            op_mulhsu: signed_mode_o = 2'b01;
            default:   signed_mode_o = 2'b00;
        endcase
    end

    assign busy_o   = is_div ? div_hold_i : mul_hold_i;
    assign result_o = is_div ? div_result_i : mul_result_i;

endmodule

/* muldiv_unit.sv */
//==========================================================================
// Top level of the RV32 M-extension execute unit.
// The pipeline holds op_valid_i and the operands until busy_o drops and
// takes the result on a cycle without stall_i.
//==========================================================================

`timescale 1ns/1ps

module muldiv_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   op_valid_i,
    input  muldiv_pkg::muldiv_op_e op_i,
    input  muldiv_pkg::word_t      operand_a_i,
    input  muldiv_pkg::word_t      operand_b_i,
    input  logic                   stall_i,
    output logic                   busy_o,
    output muldiv_pkg::word_t      result_o
);

    import muldiv_pkg::*;

    logic         mul_enable;
    signed_mode_t signed_mode;
    logic         mul_low;
    logic         single_cycle;
    logic         div_enable;
    logic         div_signed;
    logic         div_rem;
    logic         mul_hold;
    word_t        mul_result;
    logic         div_hold;
    word_t        div_result;

    muldiv_ctrl u_muldiv_ctrl (
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .mul_hold_i     (mul_hold),
        .mul_result_i   (mul_result),
        .div_hold_i     (div_hold),
        .div_result_i   (div_result),
        .mul_enable_o   (mul_enable),
        .signed_mode_o  (signed_mode),
        .mul_low_o      (mul_low),
        .single_cycle_o (single_cycle),
        .div_enable_o   (div_enable),
        .div_signed_o   (div_signed),
        .div_rem_o      (div_rem),
        .busy_o         (busy_o),
        .result_o       (result_o)
    );

    mul u_mul (
        .clk              (clk),
        .reset_n          (reset_n),
        .stall_i          (stall_i),
        .first_operand_i  (operand_a_i),
        .second_operand_i (operand_b_i),
        .signed_mode_i    (signed_mode),
        .enable_i         (mul_enable),
        .mul_low_i        (mul_low),
        .single_cycle_i   (single_cycle),
        .hold_o           (mul_hold),
        .result_o         (mul_result)
    );

    div u_div (
        .clk        (clk),
        .reset_n    (reset_n),
        .stall_i    (stall_i),
        .dividend_i (operand_a_i),
        .divisor_i  (operand_b_i),
        .enable_i   (div_enable),
        .signed_i   (div_signed),
        .rem_i      (div_rem),
        .hold_o     (div_hold),
        .result_o   (div_result)
    );

endmodule

/* tb_muldiv_model.svh */
//==========================================================================
// Reference results and latencies of the M-extension operations.
// Included inside the testbench module after the package import.
//==========================================================================

`ifndef TB_MULDIV_MODEL_SVH
`define TB_MULDIV_MODEL_SVH

function automatic word_t model_result(input muldiv_op_e op, input word_t a, input word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [63:0]        prod_ss;
    logic [63:0]        prod_su;
    logic [63:0]        prod_uu;
    logic               ovf;
    sa      = a;
    sb      = b;
    ovf     = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    // the low 64 bits of a product of sign-extended words equal the signed product
    prod_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    prod_su = {{32{a[31]}}, a} * {32'h0, b};
    prod_uu = {32'h0, a} * {32'h0, b};
    case (op)
        op_mul:    return prod_ss[31:0];
        op_mulh:   return prod_ss[63:32];
        op_mulhsu: return prod_su[63:32];
        op_mulhu:  return prod_uu[63:32];
        op_div:    return (b == 0) ? 32'hffff_ffff : (ovf ? a : word_t'(sa / sb));
        op_divu:   return (b == 0) ? 32'hffff_ffff : a / b;
        op_rem:    return (b == 0) ? a : (ovf ? 32'h0 : word_t'(sa % sb));
        default:   return (b == 0) ? a : a % b;
    endcase
endfunction

// a word fits a half when its upper 16 bits only repeat a zero or a set bit 15
function automatic logic fits_half(input word_t v);
    return (v[31:16] == 16'h0000) || (v[31:15] == 17'h1_ffff);
endfunction

function automatic int model_latency(input muldiv_op_e op, input word_t a, input word_t b);
    case (op)
        op_mul:                       return (fits_half(a) && fits_half(b)) ? 2 : 3;
        op_mulh, op_mulhsu, op_mulhu: return 4;
        op_div, op_rem: begin
            if (b == 0 || (a == 32'h8000_0000 && b == 32'hffff_ffff)) return 1;
            return 34;
        end
        default:                      return (b == 0) ? 1 : 34;
    endcase
endfunction

`endif

/* tb_muldiv.sv */
//==========================================================================
// Testbench for the multiply/divide unit. Directed and random operations
// are checked against a reference model for value, latency and stalls.
//==========================================================================

`timescale 1ns/1ps

module tb_muldiv;

    import muldiv_pkg::*;

    `include "tb_muldiv_model.svh"

    localparam int clk_period     = 40;
    localparam int max_op_cycles  = 40;
    localparam int num_short      = 24;
    localparam int num_special    = 12;
    localparam int num_random     = 400;
    localparam int total_ops      = num_short + num_special + num_random;

    logic       clk;
    logic       reset_n;
    logic       op_valid;
    muldiv_op_e op;
    word_t      operand_a;
    word_t      operand_b;
    logic       stall;
    logic       busy;
    word_t      result;

    integer     seed;
    word_t      rnd;
    int         op_count;
    int         mismatch_count;
    int         timing_count;
    int         hang_count;

    muldiv_unit u_muldiv_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .op_valid_i  (op_valid),
        .op_i        (op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .stall_i     (stall),
        .busy_o      (busy),
        .result_o    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // mostly edge values and short words, since those steer the fast paths
    function automatic word_t pick_operand();
        word_t r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return {{16{r[31]}}, r[31:16]};
            3'd4:    return {16'h0000, r[31:16]};
            default: return $random(seed);
        endcase
    endfunction

    function automatic word_t short_operand();
        word_t r;
        r = $random(seed);
        return r[0] ? {{16{r[31]}}, r[31:16]} : {16'h0000, r[31:16]};
    endfunction

    function automatic int pick_stall();
        word_t r;
        r = $random(seed);
        return (r[1:0] == 2'b00) ? 1 + int'(r[7:4]) % 5 : 0;
    endfunction

    // holds one request until it is taken, stalling the due result for stall_len cycles
    task automatic run_op(input muldiv_op_e op_in, input word_t a_in, input word_t b_in,
                          input int stall_len);
        word_t expected;
        int    exp_cycles;
        int    cycle;
        int    first_ready;
        int    stalled;
        logic  accepted;
        expected    = model_result(op_in, a_in, b_in);
        exp_cycles  = model_latency(op_in, a_in, b_in);
        cycle       = 0;
        first_ready = 0;
        stalled     = 0;
        accepted    = 1'b0;
        while (!accepted && cycle < max_op_cycles) begin
            @(negedge clk);
            cycle     = cycle + 1;
            op_valid  = 1'b1;
            op        = op_in;
            operand_a = a_in;
            operand_b = b_in;
            stall     = (cycle >= exp_cycles) && (stalled < stall_len);
            #(clk_period / 4);
            if (!busy && first_ready == 0) begin
                first_ready = cycle;
            end
            if (stall || !busy) begin
                assert (!busy && result == expected) else begin
                    mismatch_count++;
                    $display("mismatch at %0t: %s a=%h b=%h expected %h actual %h busy=%b",
                             $time, op_in.name(), a_in, b_in, expected, result, busy);
                end
                if (stall) begin
                    stalled++;
                end else begin
                    accepted = 1'b1;
                end
            end
        end
        assert (accepted) else begin
            hang_count++;
            $display("error at %0t: %s a=%h b=%h did not finish within %0d cycles",
                     $time, op_in.name(), a_in, b_in, max_op_cycles);
        end
        if (accepted) begin
            op_count++;
            assert (first_ready == exp_cycles) else begin
                timing_count++;
                $display("mismatch at %0t: %s a=%h b=%h result after %0d cycles, expected %0d",
                         $time, op_in.name(), a_in, b_in, first_ready, exp_cycles);
            end
        end
    endtask

    task automatic idle_cycles(input int count);
        word_t junk;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            junk      = $random(seed);
            op_valid  = 1'b0;
            op        = muldiv_op_e'(junk[2:0]);
            operand_a = junk;
            operand_b = ~junk;
            stall     = 1'b0;
            #(clk_period / 4);
            assert (!busy) else begin
                mismatch_count++;
                $display("mismatch at %0t: busy_o high while op_valid_i is low", $time);
            end
        end
    endtask

    initial begin
        seed           = 86;
        op_count       = 0;
        mismatch_count = 0;
        timing_count   = 0;
        hang_count     = 0;
        reset_n        = 1'b0;
        op_valid       = 1'b0;
        op             = op_mul;
        operand_a      = '0;
        operand_b      = '0;
        stall          = 1'b0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        idle_cycles(3);

        for (int i = 0; i < num_short; i++) begin
            run_op(op_mul, short_operand(), short_operand(), pick_stall());
        end

        // divide by zero, signed overflow and zero by zero for each divide op
        for (int i = 0; i < 4; i++) begin
            run_op(muldiv_op_e'(3'(4 + i)), pick_operand(), 32'h0, pick_stall());
            run_op(muldiv_op_e'(3'(4 + i)), 32'h8000_0000, 32'hffff_ffff, pick_stall());
            run_op(muldiv_op_e'(3'(4 + i)), 32'h0, 32'h0, pick_stall());
        end

        for (int i = 0; i < num_random; i++) begin
            rnd = $random(seed);
            run_op(muldiv_op_e'(rnd[2:0]), pick_operand(), pick_operand(), pick_stall());
            if (rnd[5:3] == 3'd0) begin
                idle_cycles(1 + int'(rnd[6]));
            end
        end
        idle_cycles(2);

        $display("summary: %0d operations, %0d value mismatches, %0d timing errors, %0d hangs",
                 op_count, mismatch_count, timing_count, hang_count);
        if (mismatch_count + timing_count + hang_count == 0 && op_count == total_ops) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((total_ops * max_op_cycles + 100) * clk_period);
        $display("timeout: the run did not complete in the allotted time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
muldiv_pkg.sv
mul.sv
div.sv
muldiv_ctrl.sv
muldiv_unit.sv
tb_muldiv.sv

/* run.sh */
#!/bin/sh
# Builds the multiply/divide testbench with Verilator and runs it.
# The exit status is zero only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_muldiv -o sim_muldiv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_muldiv 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
